// File: list.f
hw/pow2_pkg.sv
hw/float_floor.sv
hw/frac_extract.sv
hw/pow2_frac.sv
hw/pow2_assemble.sv
hw/pow2_top.sv
verif/pow2_properties.sv
verif/pow2_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the pow2 testbench

LOG_FILE=sim.log
OBJ_DIR=obj_dir
SIM_BIN=pow2_sim

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module pow2_tb \
	-Mdir "$OBJ_DIR" -o "$SIM_BIN" \
	-f list.f
if [ $? -ne 0 ]; then
	echo "ERROR: Verilator build failed"
	exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "Test failures found" "$LOG_FILE"; then
	echo "FAIL: failures reported in $LOG_FILE"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "FAIL: simulation exited with status $sim_status"
	exit 1
fi

echo "PASS"
exit 0

// File: verif/pow2_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pow2_tb;
	import pow2_pkg::*;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 10;
	localparam int N_PAIRS      = 16;
	localparam int N_RANDOM     = 520;
	localparam int N_TOTAL      = 32 + 2 * N_PAIRS + 8 + 8 + N_RANDOM;
	localparam int MAX_GAP      = 3;
	localparam int WATCHDOG_NS  = CLK_PERIOD * (RESET_CYCLES + N_TOTAL * (1 + MAX_GAP) + 100);

	// One expected output with the cycle its input was driven
	typedef struct packed {
		float32_t    x;
		float32_t    res;
		logic        ovf;
		logic [31:0] cycle;
	} expect_t;

	logic        clk = 1'b0;
	logic        reset;
	logic        valid_in;
	float32_t    x;
	float32_t    result;
	logic        overflow;
	logic        valid_out;

	logic [31:0] cycle_count = '0;
	int          seed;
	int          seg_table [0:16];
	expect_t     exp_q [$];
	expect_t     mon_item;

	// |x| of 32 and above, infinities and NaNs
	logic [31:0] ovf_vals [0:7] = '{32'h42000000, 32'h42c80000, 32'hc2040000, 32'h7f7fffff,
		32'h7f800000, 32'hff800000, 32'h7fc00000, 32'h7f800001};

	// Magnitudes below one and one denormal
	logic [31:0] small_vals [0:7] = '{32'h3f000000, 32'h3e800000, 32'h3f400000, 32'h3d800000,
		32'h00000001, 32'h3f7fffff, 32'hbf000000, 32'h2edbe6ff};

	pow2_top uut (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.x         (x),
		.result    (result),
		.overflow  (overflow),
		.valid_out (valid_out)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 32'd1;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// 2^(i/16) as a mantissa field rounded to nearest
	task automatic fill_table();
		for (int i = 0; i <= 16; i++) begin
			seg_table[i] = $rtoi($pow(2.0, $itor(i) / 16.0) * 8388608.0 + 0.5) - 8388608;
		end
	endtask

	// Q0.16 fraction of |x| with lower bits truncated
	function automatic logic [15:0] model_frac(input float32_t v);
		logic [63:0] sig;
		logic [63:0] q;
		sig = {40'd0, (v.exp != 8'd0), v.man};
		q   = sig >> (134 - int'(v.exp));
		return q[15:0];
	endfunction

	task automatic model_pow2(input float32_t v, output float32_t res, output logic ovf);
		logic [63:0] sig;
		logic [15:0] f;
		int          k;
		int          seg;
		longint      lerp;
		longint      lo;
		longint      hi;
		longint      m;
		res.sign = 1'b0;
		ovf      = (v.exp >= 8'(EXP_BIAS + 5));
		if (ovf) begin
			res.exp = 8'(EXP_INF);
			res.man = '0;
		end else begin
			sig = {40'd0, 1'b1, v.man};
			k   = 0;
			if (v.exp >= 8'(EXP_BIAS)) begin
				k = int'(sig >> (150 - int'(v.exp)));
			end
			f    = model_frac(v);
			seg  = int'(f[15:12]);
			lerp = longint'(f[11:0]);
			lo   = longint'(seg_table[seg]);
			hi   = longint'(seg_table[seg + 1]);
			m    = lo + (((hi - lo) * lerp) >> 12);
			res.exp = 8'(EXP_BIAS + k);
			res.man = m[22:0];
		end
	endtask

	function automatic float32_t int_to_float(input int k);
		float32_t    f;
		logic [31:0] u;
		int          p;
		f = '0;
		if (k > 0) begin
			u = 32'(k);
			p = 0;
			for (int b = 0; b < 32; b++) begin
				if (u[b]) begin
					p = b;
				end
			end
			f.exp = 8'(EXP_BIAS + p);
			f.man = 23'(u << (23 - p));
		end
		return f;
	endfunction

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_result(input string name, input float32_t actual,
			input float32_t expected, input float32_t stim);
		if (actual !== expected) begin
			abort_run($sformatf("MISMATCH %s: actual %h expected %h for input %h",
				name, actual, expected, stim));
		end
	endtask

	task automatic check_flag(input string name, input logic actual,
			input logic expected, input float32_t stim);
		if (actual !== expected) begin
			abort_run($sformatf("MISMATCH %s: actual %h expected %h for input %h",
				name, actual, expected, stim));
		end
	endtask

	// Outputs change on the rising edge, so look at them on the falling one
	always @(negedge clk) begin
		if (reset) begin
			if (valid_out !== 1'b0) begin
				abort_run("valid_out was not low during reset");
			end
		end else if (valid_out === 1'b1) begin
			if (exp_q.size() == 0) begin
				abort_run("valid_out went high with no sample in flight");
			end else begin
				mon_item = exp_q.pop_front();
				if (cycle_count - mon_item.cycle != 32'd4) begin
					abort_run($sformatf("Output for input %h came %0d cycles after it, not 4",
						mon_item.x, cycle_count - mon_item.cycle));
				end
				check_result("result", result, mon_item.res, mon_item.x);
				check_flag("overflow", overflow, mon_item.ovf, mon_item.x);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic send_expect(input float32_t v, input float32_t res, input logic ovf);
		expect_t item;
		x          = v;
		valid_in   = 1'b1;
		item.x     = v;
		item.res   = res;
		item.ovf   = ovf;
		item.cycle = cycle_count;
		exp_q.push_back(item);
		@(posedge clk);
		#1;
		valid_in = 1'b0;
	endtask

	task automatic send_sample(input float32_t v);
		float32_t res;
		logic     ovf;
		model_pow2(v, res, ovf);
		send_expect(v, res, ovf);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		float32_t    v;
		float32_t    neg;
		float32_t    res;
		logic        ovf;
		logic [31:0] r;
		logic [31:0] r2;
		int          drain;

		// Samples offered while in reset must never reach the output
		reset    = 1'b1;
		valid_in = 1'b1;
		x        = 32'h3fc00000;
		seed     = 32'hbbd1;
		fill_table();

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset    = 1'b0;
		valid_in = 1'b0;
		idle_cycles(2);

		// Whole numbers give exact powers of two
		for (int k = 0; k < 32; k++) begin
			res.sign = 1'b0;
			res.exp  = 8'(EXP_BIAS + k);
			res.man  = '0;
			send_expect(int_to_float(k), res, 1'b0);
		end

		// Sign is ignored
		for (int i = 0; i < N_PAIRS; i++) begin
			r      = $random(seed);
			r2     = $random(seed);
			v.sign = 1'b0;
			v.exp  = 8'(100 + int'(r[30:0] % 31'd32));
			v.man  = r2[22:0];
			model_pow2(v, res, ovf);
			neg      = v;
			neg.sign = 1'b1;
			send_expect(v, res, ovf);
			send_expect(neg, res, ovf);
		end

		res.sign = 1'b0;
		res.exp  = 8'(EXP_INF);
		res.man  = '0;
		for (int i = 0; i < 8; i++) begin
			v = ovf_vals[i];
			send_expect(v, res, 1'b1);
		end

		for (int i = 0; i < 8; i++) begin
			v = small_vals[i];
			send_sample(v);
		end
		idle_cycles(3);

		// Mostly back to back with a few short gaps
		for (int i = 0; i < N_RANDOM; i++) begin
			r      = $random(seed);
			r2     = $random(seed);
			v.sign = r[31];
			v.exp  = 8'(100 + int'(r[30:0] % 31'd41));
			v.man  = r2[22:0];
			send_sample(v);
			if (r2[26:24] == 3'd0) begin
				idle_cycles(1 + int'(r2[28:27] % 2'd3));
			end
		end

		drain = 0;
		while (exp_q.size() != 0 && drain < 20) begin
			@(posedge clk);
			drain++;
		end
		// A few more cycles to catch any stray valid_out
		repeat (8) @(posedge clk);

		if (exp_q.size() == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			abort_run($sformatf("%0d expected outputs never arrived", exp_q.size()));
		end
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("Timeout: the run did not finish in the expected time");
	end

endmodule

`default_nettype wire

// File: verif/pow2_properties.sv
`timescale 1ns/1ps
`default_nettype none

module pow2_properties (
	input logic               clk,
	input logic               reset,
	input logic               valid_in,
	input pow2_pkg::float32_t x,
	input logic               valid_out,
	input logic               overflow,
	input pow2_pkg::float32_t result
);
	import pow2_pkg::*;

	// Each input accepted outside reset gives exactly one strobe four cycles later
	a_latency: assert property (
		@(posedge clk) disable iff (reset)
		valid_out == $past(valid_in && !reset, 4)
	) else $error("valid_out does not follow valid_in by exactly four cycles");

	// Output strobe stays low while reset is applied
	a_reset_quiet: assert property (
		@(posedge clk)
		$past(reset) |-> !valid_out
	) else $error("valid_out high during reset");

	// Magnitude of 32 or more, inf or NaN comes out as overflow with exponent 255
	a_ovf_inf: assert property (
		@(posedge clk) disable iff (reset)
		valid_out |-> ((overflow == ($past(x.exp, 4) >= 8'(EXP_BIAS + 5))) &&
			(!overflow || (result.exp == 8'(EXP_INF))))
	) else $error("overflow does not match the input range or lacks an all-ones exponent");

endmodule

bind pow2_top pow2_properties u_properties (
	.clk       (clk),
	.reset     (reset),
	.valid_in  (valid_in),
	.x         (x),
	.valid_out (valid_out),
	.overflow  (overflow),
	.result    (result)
);

`default_nettype wire

// File: hw/pow2_top.sv
`timescale 1ns/1ps
`default_nettype none

module pow2_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               valid_in,
	input  pow2_pkg::float32_t x,
	output pow2_pkg::float32_t result,
	output logic               overflow,
	output logic               valid_out
);
	import pow2_pkg::*;

	float32_t    int_part;
	frac_t       fr;
	logic        frac_valid;
	logic [22:0] mant;
	logic        ovf;
	logic        mant_valid;

	////////////////////////////////////////////////////////////
	// Producers
	////////////////////////////////////////////////////////////

	// Floor strobe stays open since the assembler aligns by cycle count
	float_floor u_floor (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.x         (x),
		.int_part  (int_part),
		.int_valid ()
	);

	frac_extract u_frac_extract (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (valid_in),
		.x          (x),
		.fr         (fr),
		.frac_valid (frac_valid)
	);

	////////////////////////////////////////////////////////////
	// Mantissa pipeline and result assembly
	////////////////////////////////////////////////////////////

	pow2_frac u_pow2_frac (
		.clk        (clk),
		.reset      (reset),
		.fr         (fr),
		.frac_valid (frac_valid),
		.mant       (mant),
		.ovf        (ovf),
		.mant_valid (mant_valid)
	);

	pow2_assemble u_assemble (
		.clk        (clk),
		.reset      (reset),
		.int_part   (int_part),
		.mant       (mant),
		.ovf        (ovf),
		.mant_valid (mant_valid),
		.result     (result),
		.overflow   (overflow),
		.valid_out  (valid_out)
	);

endmodule

`default_nettype wire

// File: hw/pow2_assemble.sv
`timescale 1ns/1ps
`default_nettype none

module pow2_assemble (
	input  logic               clk,
	input  logic               reset,
	input  pow2_pkg::float32_t int_part,
	input  logic [22:0]        mant,
	input  logic               ovf,
	input  logic               mant_valid,
	output pow2_pkg::float32_t result,
	output logic               overflow,
	output logic               valid_out
);
	import pow2_pkg::*;

	float32_t                         int_q1;
	float32_t                         int_q2;
	logic [2:0]                       shift;
	logic [$clog2(INT_MAX + 1)-1:0]   k;
	float32_t                         res_next;

	// Floor arrives two cycles ahead of the mantissa
	always_ff @(posedge clk) begin
		int_q1 <= int_part;
		int_q2 <= int_q1;
	end

	////////////////////////////////////////////////////////////
	// Integer k from the delayed floor value
	////////////////////////////////////////////////////////////

	always_comb begin
		shift = 3'(int_q2.exp - 8'(EXP_BIAS));
		if (int_q2.exp == 8'd0) begin
			k = '0;
		end else begin
			// Hidden bit plus top four mantissa bits cover 1..31
			k = 5'({1'b1, int_q2.man[22 -: 4]} >> (3'd4 - shift));
		end

		res_next.sign = 1'b0;
		if (ovf) begin
			res_next.exp = 8'(EXP_INF);
			res_next.man = '0;
		end else begin
			res_next.exp = 8'(EXP_BIAS + k);
			res_next.man = mant;
		end
	end

	always_ff @(posedge clk) begin
		if (mant_valid) begin
			result <= res_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			overflow  <= 1'b0;
			valid_out <= 1'b0;
		end else begin
			valid_out <= mant_valid;
			if (mant_valid) begin
				overflow <= ovf;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/pow2_frac.sv
`timescale 1ns/1ps
`default_nettype none

module pow2_frac (
	input  logic            clk,
	input  logic            reset,
	input  pow2_pkg::frac_t fr,
	input  logic            frac_valid,
	output logic [22:0]     mant,
	output logic            ovf,
	output logic            mant_valid
);
	import pow2_pkg::*;

	logic [SEG_BITS-1:0]       seg;
	logic [LERP_BITS-1:0]      lerp;
	logic [23:0]               lo_entry;
	logic [23:0]               hi_entry;
	logic [22:0]               base_q;
	logic [23:0]               diff_q;
	logic [LERP_BITS-1:0]      lerp_q;
	logic                      ovf_q;
	logic                      valid_q;
	logic [23+LERP_BITS:0]     prod;

	// Mantissa field of 2^(i/16) rounded to nearest
	function automatic logic [23:0] seg_entry(input logic [SEG_BITS:0] idx);
		logic [23:0] val;
		case (idx)
			5'd0:    val = 24'd0;
			5'd1:    val = 24'd371395;
			5'd2:    val = 24'd759234;
			5'd3:    val = 24'd1164243;
			5'd4:    val = 24'd1587184;
			5'd5:    val = 24'd2028850;
			5'd6:    val = 24'd2490071;
			5'd7:    val = 24'd2971711;
			5'd8:    val = 24'd3474675;
			5'd9:    val = 24'd3999908;
			5'd10:   val = 24'd4548394;
			5'd11:   val = 24'd5121164;
			5'd12:   val = 24'd5719293;
			5'd13:   val = 24'd6343903;
			5'd14:   val = 24'd6996167;
			5'd15:   val = 24'd7677309;
			// Endpoint 2^1 sits one full step above the hidden bit
			default: val = 24'd8388608;
		endcase
		return val;
	endfunction

	////////////////////////////////////////////////////////////
	// Stage 1: table lookup
	////////////////////////////////////////////////////////////

	always_comb begin
		seg      = fr.frac[FRAC_W-1 -: SEG_BITS];
		lerp     = fr.frac[LERP_BITS-1:0];
		lo_entry = seg_entry({1'b0, seg});
		hi_entry = seg_entry({1'b0, seg} + 1'b1);
	end

	always_ff @(posedge clk) begin
		if (frac_valid) begin
			base_q <= lo_entry[22:0];
			diff_q <= hi_entry - lo_entry;
			lerp_q <= lerp;
			ovf_q  <= fr.ovf;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 2: linear interpolation
	////////////////////////////////////////////////////////////

	// Sum stays below the next entry, so it fits 23 bits
	assign prod = diff_q * lerp_q;

	always_ff @(posedge clk) begin
		if (valid_q) begin
			mant <= base_q + 23'(prod >> LERP_BITS);
			ovf  <= ovf_q;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q    <= 1'b0;
			mant_valid <= 1'b0;
		end else begin
			valid_q    <= frac_valid;
			mant_valid <= valid_q;
		end
	end

endmodule

`default_nettype wire

// File: hw/frac_extract.sv
`timescale 1ns/1ps
`default_nettype none

module frac_extract (
	input  logic               clk,
	input  logic               reset,
	input  logic               valid_in,
	input  pow2_pkg::float32_t x,
	output pow2_pkg::frac_t    fr,
	output logic               frac_valid
);
	import pow2_pkg::*;

	logic [7:0]  unb_exp;
	logic [7:0]  rsh;
	logic [23:0] sig;
	logic [22:0] man_shl;
	frac_t       fr_next;

	always_comb begin
		// Hidden bit only for normal numbers
		sig     = {|x.exp, x.man};
		unb_exp = x.exp - 8'(EXP_BIAS);
		rsh     = 8'(EXP_BIAS) - x.exp;
		man_shl = x.man << unb_exp[2:0];

		// Overflow for |x| >= 32 and for inf and NaN
		fr_next.ovf = (x.exp >= 8'(EXP_BIAS + $clog2(INT_MAX + 1)));

		if (x.exp >= 8'(EXP_BIAS)) begin
			// Integer bits fall off the top of the mantissa
			fr_next.frac = man_shl[22 -: FRAC_W];
		end else begin
			// Whole significand lies below the point
			fr_next.frac = FRAC_W'(sig >> (rsh + 8'(23 - FRAC_W)));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			frac_valid <= 1'b0;
		end else begin
			frac_valid <= valid_in;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in) begin
			fr <= fr_next;
		end
	end

endmodule

`default_nettype wire

// File: hw/float_floor.sv
`timescale 1ns/1ps
`default_nettype none

module float_floor (
	input  logic               clk,
	input  logic               reset,
	input  logic               valid_in,
	input  pow2_pkg::float32_t x,
	output pow2_pkg::float32_t int_part,
	output logic               int_valid
);
	import pow2_pkg::*;

	logic [7:0]  unb_exp;
	logic [22:0] frac_mask;
	logic        in_range;
	float32_t    floor_val;

	////////////////////////////////////////////////////////////
	// Floor by masking the bits below the binary point
	////////////////////////////////////////////////////////////

	always_comb begin
		unb_exp = x.exp - 8'(EXP_BIAS);

		// 1 <= |x| < 32 means an unbiased exponent of 0 to 4
		in_range = (x.exp >= 8'(EXP_BIAS)) &&
			(unb_exp < 8'($clog2(INT_MAX + 1)));

		// Each exponent step moves one mantissa bit above the point
		frac_mask = 23'h7fffff >> unb_exp[2:0];

		if (in_range) begin
			floor_val.sign = 1'b0;
			floor_val.exp  = x.exp;
			floor_val.man  = x.man & ~frac_mask;
		end else begin
			// Below one, or too large for the table range
			floor_val = '0;
		end
	end

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			int_valid <= 1'b0;
		end else begin
			int_valid <= valid_in;
		end
	end

	// Holds the last sample between strobes
	always_ff @(posedge clk) begin
		if (valid_in) begin
			int_part <= floor_val;
		end
	end

endmodule

`default_nettype wire

// File: hw/pow2_pkg.sv
`default_nettype none

package pow2_pkg;

	////////////////////////////////////////////////////////////
	// Float format constants
	////////////////////////////////////////////////////////////

	localparam int EXP_BIAS = 127;
	localparam int EXP_INF  = 255;

	// Largest integer part that still gives a finite result
	localparam int INT_MAX  = 31;

	////////////////////////////////////////////////////////////
	// Fraction datapath
	////////////////////////////////////////////////////////////

	// Q0.16 fraction whose top bits select a table segment
	localparam int FRAC_W    = 16;
	localparam int SEG_BITS  = 4;
	localparam int LERP_BITS = 12;

	// IEEE single precision layout
	typedef struct packed {
		logic        sign;
		logic [7:0]  exp;
		logic [22:0] man;
	} float32_t;

	// Fraction of |x| plus out-of-range flag
	typedef struct packed {
		logic              ovf;
		logic [FRAC_W-1:0] frac;
	} frac_t;

endpackage

`default_nettype wire
